// ==== logic/raster_pkg.sv ====
// shared widths, APB register map and reset defaults
// for the raster bar generator

`default_nettype none

package raster_pkg;

    // colour and coordinate widths
    localparam int colr_w = 12;  // 4 bits per channel
    localparam int chan_w = 4;   // one channel of r, g, b
    localparam int cord_w = 10;  // screen coordinate
    localparam int cfg_w  = 4;   // steps and lines fields

    // brightness step, one count per channel
    localparam logic [colr_w-1:0] colr_step = 12'h111;

    // APB word offsets
    localparam int addr_w = 4;
    localparam logic [addr_w-1:0] reg_ctrl  = 4'h0;  // bit 0 enable
    localparam logic [addr_w-1:0] reg_start = 4'h4;  // start colour
    localparam logic [addr_w-1:0] reg_steps = 4'h8;  // colours per bar
    localparam logic [addr_w-1:0] reg_lines = 4'hC;  // lines per colour

    // register reset values
    localparam logic              def_en    = 1'b1;
    localparam logic [colr_w-1:0] def_start = 12'h126;  // dark blue
    localparam logic [cfg_w-1:0]  def_steps = 4'd10;
    localparam logic [cfg_w-1:0]  def_lines = 4'd2;

endpackage

`default_nettype wire

// ==== logic/display_timing.sv ====
// display timing: horizontal and vertical counters with
// active-low sync and data-enable decode

`default_nettype none
`timescale 1ns/10ps

module display_timing
    import raster_pkg::*;
#(
    parameter int h_res  = 640,  // active pixels
    parameter int h_fp   = 16,
    parameter int h_sync = 96,
    parameter int h_bp   = 48,
    parameter int v_res  = 480,  // active lines
    parameter int v_fp   = 10,
    parameter int v_sync = 2,
    parameter int v_bp   = 33
) (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    output      logic [cord_w-1:0] sx,     // horizontal position
    output      logic [cord_w-1:0] sy,     // vertical position
    output      logic              hsync,  // active low
    output      logic              vsync,  // active low
    output      logic              de      // active area
);

    localparam int h_full = h_res + h_fp + h_sync + h_bp;
    localparam int v_full = v_res + v_fp + v_sync + v_bp;

    // decode points in coordinate width
    localparam logic [cord_w-1:0] h_act  = cord_w'(h_res);
    localparam logic [cord_w-1:0] v_act  = cord_w'(v_res);
    localparam logic [cord_w-1:0] hs_sta = cord_w'(h_res + h_fp);
    localparam logic [cord_w-1:0] hs_end = cord_w'(h_res + h_fp + h_sync);
    localparam logic [cord_w-1:0] vs_sta = cord_w'(v_res + v_fp);
    localparam logic [cord_w-1:0] vs_end = cord_w'(v_res + v_fp + v_sync);
    localparam logic [cord_w-1:0] h_last = cord_w'(h_full - 1);
    localparam logic [cord_w-1:0] v_last = cord_w'(v_full - 1);

    // sync and enable straight from the counters
    always_comb begin
        hsync = ~((sx >= hs_sta) && (sx < hs_end));  // low in sync window
        vsync = ~((sy >= vs_sta) && (sy < vs_end));
        de    = (sx < h_act) && (sy < v_act);
    end

    // full line and full frame, blanking included
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == h_last) begin  // end of line
            sx <= '0;
            if (sy == v_last) begin       // end of frame
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // line counter wraps before the full width
    sx_in_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx <= h_last)
        else $error("sx beyond line width: %0d", sx);

endmodule

`default_nettype wire

// ==== logic/bar_regs.sv ====
// APB slave with the raster bar configuration registers
// enable, start colour, colours per bar, lines per colour

`default_nettype none
`timescale 1ns/10ps

module bar_regs
    import raster_pkg::*;
(
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [addr_w-1:0] paddr,
    input  wire logic [31:0]       pwdata,
    output      logic [31:0]       prdata,
    output      logic              pready,
    output      logic              pslverr,
    output      logic              cfg_en,     // bars on
    output      logic [colr_w-1:0] cfg_start,  // first colour of frame
    output      logic [cfg_w-1:0]  cfg_steps,  // colours per bar
    output      logic [cfg_w-1:0]  cfg_lines   // lines per colour
);

    logic acc;     // access phase of a transfer
    logic hit;     // offset is mapped
    logic wr_en;

    assign acc    = psel && penable;
    assign wr_en  = acc && pwrite && hit;  // unmapped writes dropped
    assign pready = 1'b1;                  // no wait states
    assign pslverr = acc && !hit;

    // address decode and read mux
    always_comb begin
        hit    = 1'b1;
        prdata = '0;
        case (paddr)
            reg_ctrl:  prdata = 32'(cfg_en);
            reg_start: prdata = 32'(cfg_start);
            reg_steps: prdata = 32'(cfg_steps);
            reg_lines: prdata = 32'(cfg_lines);
            default:   hit = 1'b0;  // hole in the map
        endcase
    end

    // write at the access edge
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cfg_en    <= def_en;
            cfg_start <= def_start;
            cfg_steps <= def_steps;
            cfg_lines <= def_lines;
        end else if (wr_en) begin
            case (paddr)
                reg_ctrl:  cfg_en    <= pwdata[0];
                reg_start: cfg_start <= pwdata[colr_w-1:0];
                reg_steps: cfg_steps <= pwdata[cfg_w-1:0];
                reg_lines: cfg_lines <= pwdata[cfg_w-1:0];
                default:   ;  // not reached, hit is low
            endcase
        end
    end

    // access phase always follows a select
    apb_enable_sel: assert property (@(posedge clk_pix) disable iff (!rst_n)
        penable |-> psel)
        else $error("penable high without psel");

endmodule

`default_nettype wire

// ==== logic/bar_colour.sv ====
// raster bar colour, updated once per line in horizontal blanking
// configuration is shadowed at the last line of each frame

`default_nettype none
`timescale 1ns/10ps

module bar_colour
    import raster_pkg::*;
#(
    parameter int h_res  = 640,
    parameter int v_res  = 480,
    parameter int v_fp   = 10,
    parameter int v_sync = 2,
    parameter int v_bp   = 33
) (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire logic [cord_w-1:0] sx,
    input  wire logic [cord_w-1:0] sy,
    input  wire logic              cfg_en,
    input  wire logic [colr_w-1:0] cfg_start,
    input  wire logic [cfg_w-1:0]  cfg_steps,
    input  wire logic [cfg_w-1:0]  cfg_lines,
    output      logic [colr_w-1:0] bar_colr
);

    localparam int v_full = v_res + v_fp + v_sync + v_bp;

    localparam logic [cord_w-1:0] line_end  = cord_w'(h_res);       // start of blanking
    localparam logic [cord_w-1:0] last_line = cord_w'(v_full - 1);

    logic              shd_en;     // frame copies of the registers
    logic [cfg_w-1:0]  shd_steps;
    logic [cfg_w-1:0]  shd_lines;
    logic [cfg_w-1:0]  eff_steps;  // zero read as one
    logic [cfg_w-1:0]  eff_lines;
    logic [colr_w-1:0] cur_colr;
    logic              bar_inc;    // brightening
    logic [cfg_w-1:0]  cnt_colr;   // colours used in this bar
    logic [cfg_w-1:0]  cnt_line;   // lines of this colour

    assign eff_steps = (cfg_steps == '0) ? cfg_w'(1) : cfg_steps;
    assign eff_lines = (cfg_lines == '0) ? cfg_w'(1) : cfg_lines;

    // black when disabled for this frame
    assign bar_colr = shd_en ? cur_colr : '0;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            shd_en    <= def_en;
            shd_steps <= def_steps;
            shd_lines <= def_lines;
            cur_colr  <= def_start;
            bar_inc   <= 1'b1;
            cnt_colr  <= '0;
            cnt_line  <= '0;
        end else if (sx == line_end) begin
            if (sy == last_line) begin  // reload for next frame
                shd_en    <= cfg_en;
                shd_steps <= eff_steps;
                shd_lines <= eff_lines;
                cur_colr  <= cfg_start;
                bar_inc   <= 1'b1;
                cnt_colr  <= '0;
                cnt_line  <= '0;
            end else if (cnt_line == shd_lines - 1'b1) begin  // colour done
                cnt_line <= '0;
                if (cnt_colr == shd_steps - 1'b1) begin  // turn around
                    bar_inc  <= ~bar_inc;
                    cnt_colr <= '0;
                end else begin
                    cur_colr <= bar_inc ? cur_colr + colr_step : cur_colr - colr_step;
                    cnt_colr <= cnt_colr + 1'b1;
                end
            end else begin
                cnt_line <= cnt_line + 1'b1;
            end
        end
    end

    // colour moves only right after the line's active area ends
    colr_in_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $changed(bar_colr) |-> ($past(sx) == line_end))
        else $error("bar colour changed outside blanking");

endmodule

`default_nettype wire

// ==== logic/pixel_out.sv ====
// output stage: blanks colour outside the active area
// and registers sync, enable and colour together

`default_nettype none
`timescale 1ns/10ps

module pixel_out
    import raster_pkg::*;
(
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire logic              hsync,
    input  wire logic              vsync,
    input  wire logic              de,
    input  wire logic [colr_w-1:0] bar_colr,
    output      logic              vid_hsync,
    output      logic              vid_vsync,
    output      logic              vid_de,
    output      logic [chan_w-1:0] vid_r,
    output      logic [chan_w-1:0] vid_g,
    output      logic [chan_w-1:0] vid_b
);

    logic [colr_w-1:0] show_colr;  // black in blanking

    assign show_colr = de ? bar_colr : '0;

    // all pins change on the same edge
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vid_hsync <= 1'b1;  // syncs idle high
            vid_vsync <= 1'b1;
            vid_de    <= 1'b0;
            {vid_r, vid_g, vid_b} <= '0;
        end else begin
            vid_hsync <= hsync;
            vid_vsync <= vsync;
            vid_de    <= de;
            {vid_r, vid_g, vid_b} <= show_colr;  // r in the top nibble
        end
    end

endmodule

`default_nettype wire

// ==== logic/raster_bars_top.sv ====
// raster bar generator top: timing, APB registers,
// bar colour and registered video output

`default_nettype none
`timescale 1ns/10ps

module raster_bars_top
    import raster_pkg::*;
#(
    parameter int h_res  = 640,
    parameter int h_fp   = 16,
    parameter int h_sync = 96,
    parameter int h_bp   = 48,
    parameter int v_res  = 480,
    parameter int v_fp   = 10,
    parameter int v_sync = 2,
    parameter int v_bp   = 33
) (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [addr_w-1:0] paddr,
    input  wire logic [31:0]       pwdata,
    output      logic [31:0]       prdata,
    output      logic              pready,
    output      logic              pslverr,
    output      logic              vid_hsync,
    output      logic              vid_vsync,
    output      logic              vid_de,
    output      logic [chan_w-1:0] vid_r,
    output      logic [chan_w-1:0] vid_g,
    output      logic [chan_w-1:0] vid_b
);

    logic [cord_w-1:0] sx;         // beam position
    logic [cord_w-1:0] sy;
    logic              hsync;
    logic              vsync;
    logic              de;
    logic              cfg_en;
    logic [colr_w-1:0] cfg_start;
    logic [cfg_w-1:0]  cfg_steps;
    logic [cfg_w-1:0]  cfg_lines;
    logic [colr_w-1:0] bar_colr;   // one colour per line

    display_timing #(
        .h_res (h_res),  .h_fp (h_fp),  .h_sync (h_sync),  .h_bp (h_bp),
        .v_res (v_res),  .v_fp (v_fp),  .v_sync (v_sync),  .v_bp (v_bp)
    ) display_timing_i (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de
    );

    bar_regs bar_regs_i (
        .clk_pix, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .cfg_en, .cfg_start, .cfg_steps, .cfg_lines
    );

    bar_colour #(
        .h_res (h_res),  .v_res (v_res),  .v_fp (v_fp),  .v_sync (v_sync),
        .v_bp  (v_bp)
    ) bar_colour_i (
        .clk_pix, .rst_n, .sx, .sy,
        .cfg_en, .cfg_start, .cfg_steps, .cfg_lines, .bar_colr
    );

    pixel_out pixel_out_i (
        .clk_pix, .rst_n, .hsync, .vsync, .de, .bar_colr,
        .vid_hsync, .vid_vsync, .vid_de, .vid_r, .vid_g, .vid_b
    );

endmodule

`default_nettype wire

// ==== dv/raster_checker.sv ====
// reference model of raster timing, bar colour and APB registers
// compares the DUT pins against the model and counts errors

`default_nettype none
`timescale 1ns/10ps

module raster_checker
    import raster_pkg::*;
#(
    parameter int h_res  = 16,
    parameter int h_fp   = 2,
    parameter int h_sync = 3,
    parameter int h_bp   = 3,
    parameter int v_res  = 8,
    parameter int v_fp   = 1,
    parameter int v_sync = 2,
    parameter int v_bp   = 1
) (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [addr_w-1:0] paddr,
    input  wire logic [31:0]       pwdata,
    input  wire logic [31:0]       prdata,
    input  wire logic              pready,
    input  wire logic              pslverr,
    input  wire logic              vid_hsync,
    input  wire logic              vid_vsync,
    input  wire logic              vid_de,
    input  wire logic [chan_w-1:0] vid_r,
    input  wire logic [chan_w-1:0] vid_g,
    input  wire logic [chan_w-1:0] vid_b,
    input  wire logic [3:0]        test_id,   // current test number
    output      int                err_sync,
    output      int                err_colr,
    output      int                err_apb
);

    localparam int h_full = h_res + h_fp + h_sync + h_bp;
    localparam int v_full = v_res + v_fp + v_sync + v_bp;
    localparam logic [colr_w-1:0] step = 12'h111;  // +1 on r, g and b

    int cnt_sync = 0;
    int cnt_colr = 0;
    int cnt_apb  = 0;

    logic              m_en;      // register model
    logic [colr_w-1:0] m_start;
    logic [3:0]        m_steps;
    logic [3:0]        m_lines;
    int                m_sx;      // beam position model
    int                m_sy;
    logic              f_en;      // copies taken once per frame
    int                f_steps;
    int                f_lines;
    logic [colr_w-1:0] colr;      // colour of the current line
    logic              up;        // brightening
    int                n_used;    // colours used in this bar
    int                n_line;    // lines shown in this colour
    logic              e_hsync;   // expected pins
    logic              e_vsync;
    logic              e_de;
    logic [colr_w-1:0] e_colr;
    logic [colr_w-1:0] dut_colr;

    assign err_sync = cnt_sync;
    assign err_colr = cnt_colr;
    assign err_apb  = cnt_apb;
    assign dut_colr = {vid_r, vid_g, vid_b};  // r in the top nibble

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset_timing";
            4'd2:    return "default_bars";
            4'd3:    return "reg_access";
            4'd4:    return "reconfig";
            4'd5:    return "disable";
            default: return "startup";
        endcase
    endfunction

    function automatic logic in_window(input int pos, input int sta, input int len);
        return (pos >= sta) && (pos < sta + len);
    endfunction

    function automatic logic is_mapped(input logic [addr_w-1:0] a);
        return (a == reg_ctrl) || (a == reg_start) || (a == reg_steps) || (a == reg_lines);
    endfunction

    // read-back of the register model with zero unused bits
    function logic [31:0] model_read(input logic [addr_w-1:0] a);
        case (a)
            reg_ctrl:  return {31'd0, m_en};
            reg_start: return {20'd0, m_start};
            reg_steps: return {28'd0, m_steps};
            reg_lines: return {28'd0, m_lines};
            default:   return 32'd0;
        endcase
    endfunction

    task automatic show_mismatch(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("mismatch %s %s: expected %0h actual %0h",
                 test_name(test_id), field, exp_v, act_v);
    endtask

    // APB transfers checked in the access cycle
    always @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            m_en    <= 1'b1;   // reset values of the map
            m_start <= 12'h126;
            m_steps <= 4'd10;
            m_lines <= 4'd2;
        end else if (psel && penable) begin
            if (pready !== 1'b1) begin  // no wait states in this slave
                show_mismatch("pready", 32'd1, 32'(pready));
                cnt_apb = cnt_apb + 1;
            end
            if (pslverr !== !is_mapped(paddr)) begin
                show_mismatch("pslverr", 32'(!is_mapped(paddr)), 32'(pslverr));
                cnt_apb = cnt_apb + 1;
            end
            if (!pwrite && is_mapped(paddr) && (prdata !== model_read(paddr))) begin
                show_mismatch("prdata", model_read(paddr), prdata);
                cnt_apb = cnt_apb + 1;
            end
            if (pwrite && is_mapped(paddr)) begin  // holes keep the map
                case (paddr)
                    reg_ctrl:  m_en    <= pwdata[0];
                    reg_start: m_start <= pwdata[11:0];
                    reg_steps: m_steps <= pwdata[3:0];
                    reg_lines: m_lines <= pwdata[3:0];
                    default:   ;
                endcase
            end
        end
    end

    // pins follow the beam model one cycle late
    always @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            m_sx    <= 0;
            m_sy    <= 0;
            f_en    <= 1'b1;
            f_steps <= 10;
            f_lines <= 2;
            colr    <= 12'h126;
            up      <= 1'b1;
            n_used  <= 0;
            n_line  <= 0;
            e_hsync <= 1'b1;  // idle pins
            e_vsync <= 1'b1;
            e_de    <= 1'b0;
            e_colr  <= '0;
        end else begin
            e_hsync <= !in_window(m_sx, h_res + h_fp, h_sync);
            e_vsync <= !in_window(m_sy, v_res + v_fp, v_sync);
            e_de    <= (m_sx < h_res) && (m_sy < v_res);
            e_colr  <= ((m_sx < h_res) && (m_sy < v_res) && f_en) ? colr : '0;
            if (m_sx == h_full - 1) begin
                m_sx <= 0;
                m_sy <= (m_sy == v_full - 1) ? 0 : m_sy + 1;
            end else begin
                m_sx <= m_sx + 1;
            end
            if (m_sx == h_res) begin  // first blanking pixel
                if (m_sy == v_full - 1) begin  // new frame settings
                    f_en    <= m_en;
                    f_steps <= (m_steps == 4'd0) ? 1 : int'(m_steps);
                    f_lines <= (m_lines == 4'd0) ? 1 : int'(m_lines);
                    colr    <= m_start;
                    up      <= 1'b1;
                    n_used  <= 0;
                    n_line  <= 0;
                end else if (n_line + 1 >= f_lines) begin
                    n_line <= 0;
                    if (n_used + 1 >= f_steps) begin  // bar turns
                        up     <= !up;
                        n_used <= 0;
                    end else begin
                        colr   <= up ? colr + step : colr - step;
                        n_used <= n_used + 1;
                    end
                end else begin
                    n_line <= n_line + 1;
                end
            end
        end
    end

    // compare mid-cycle when pins and model have settled
    always @(negedge clk_pix) begin
        if ((vid_hsync !== e_hsync) || (vid_vsync !== e_vsync) || (vid_de !== e_de)) begin
            show_mismatch("hsync/vsync/de", {29'd0, e_hsync, e_vsync, e_de},
                          {29'd0, vid_hsync, vid_vsync, vid_de});
            cnt_sync = cnt_sync + 1;
        end
        if (!vid_de && (dut_colr !== '0)) begin
            show_mismatch("blanking colour", 32'd0, 32'(dut_colr));
            cnt_colr = cnt_colr + 1;
        end
        if (dut_colr !== e_colr) begin
            show_mismatch("colour", 32'(e_colr), 32'(dut_colr));
            cnt_colr = cnt_colr + 1;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_raster_bars.sv ====
// testbench top with clock, reset, APB master, random register traffic,
// frame-based test sequence, timeout and final report

`default_nettype none
`timescale 1ns/10ps

module tb_raster_bars
    import raster_pkg::*;
();

    localparam int h_res  = 16;  // small frame of 24 x 12 with blanking
    localparam int h_fp   = 2;
    localparam int h_sync = 3;
    localparam int h_bp   = 3;
    localparam int v_res  = 8;
    localparam int v_fp   = 1;
    localparam int v_sync = 2;
    localparam int v_bp   = 1;
    localparam int frame_cycles = (h_res + h_fp + h_sync + h_bp)
                                * (v_res + v_fp + v_sync + v_bp);
    localparam int n_frames     = 19;  // worst case of the sequence below
    localparam int cycle_limit  = (n_frames + 3) * frame_cycles;

    logic              clk_pix = 1'b0;
    logic              rst_n   = 1'b0;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              vid_hsync;
    logic              vid_vsync;
    logic              vid_de;
    logic [chan_w-1:0] vid_r;
    logic [chan_w-1:0] vid_g;
    logic [chan_w-1:0] vid_b;
    logic [3:0]        test_id;
    logic [31:0]       rand_state = 32'h5148_9984;
    int                cycles = 0;
    int                err_sync;
    int                err_colr;
    int                err_apb;

    always #20 clk_pix = ~clk_pix;  // 40 ns period

    raster_bars_top #(
        .h_res (h_res),  .h_fp (h_fp),  .h_sync (h_sync),  .h_bp (h_bp),
        .v_res (v_res),  .v_fp (v_fp),  .v_sync (v_sync),  .v_bp (v_bp)
    ) raster_bars_top_i (
        .clk_pix, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .vid_hsync, .vid_vsync, .vid_de, .vid_r, .vid_g, .vid_b
    );

    raster_checker #(
        .h_res (h_res),  .h_fp (h_fp),  .h_sync (h_sync),  .h_bp (h_bp),
        .v_res (v_res),  .v_fp (v_fp),  .v_sync (v_sync),  .v_bp (v_bp)
    ) checker_i (
        .clk_pix, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .vid_hsync, .vid_vsync, .vid_de, .vid_r, .vid_g, .vid_b,
        .test_id, .err_sync, .err_colr, .err_apb
    );

    // 32-bit LCG
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [addr_w-1:0] reg_offset(input int idx);
        case (idx)
            0:       return reg_ctrl;
            1:       return reg_start;
            2:       return reg_steps;
            default: return reg_lines;
        endcase
    endfunction

    // setup cycle, access cycle, then idle
    task automatic apb_transfer(input logic wr, input logic [addr_w-1:0] addr,
                                input logic [31:0] data);
        @(negedge clk_pix);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk_pix);
        penable = 1'b1;
        @(posedge clk_pix);
        while (!pready) begin  // no wait states expected
            @(posedge clk_pix);
        end
        @(negedge clk_pix);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(negedge vid_vsync);
    endtask

    task automatic wait_active();
        @(posedge vid_de);  // first pixel of a line
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        test_id = 4'd0;
        repeat (2) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_n = 1'b1;

        test_id = 4'd1;  // timing after reset
        wait_frames(2);
        test_id = 4'd2;  // bars from reset values
        wait_frames(2);

        test_id = 4'd3;  // register access
        wait_frames(1);
        for (int i = 0; i < 4; i++) begin
            apb_transfer(1'b1, reg_offset(i), next_rand());
            apb_transfer(1'b0, reg_offset(i), 32'd0);
        end
        apb_transfer(1'b1, 4'h2, next_rand());  // holes in the map
        apb_transfer(1'b0, 4'h6, 32'd0);
        for (int i = 0; i < 4; i++) begin
            apb_transfer(1'b0, reg_offset(i), 32'd0);
        end
        apb_transfer(1'b1, reg_ctrl, 32'd1);
        wait_frames(1);

        test_id = 4'd4;  // new settings mid-frame
        repeat (3) begin
            wait_active();
            apb_transfer(1'b1, reg_start, next_rand() & 32'h0000_0fff);
            apb_transfer(1'b1, reg_steps, next_rand() % 6);   // 0 reads as 1
            apb_transfer(1'b1, reg_lines, next_rand() % 4);
            wait_frames(2);
        end

        test_id = 4'd5;  // bars off while syncs keep running
        wait_active();
        apb_transfer(1'b1, reg_ctrl, 32'd0);
        wait_frames(2);

        $display("errors: sync %0d, colour %0d, apb %0d", err_sync, err_colr, err_apb);
        if (err_sync + err_colr + err_apb == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("errors: sync %0d, colour %0d, apb %0d", err_sync, err_colr, err_apb);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/raster_pkg.sv
logic/display_timing.sv
logic/bar_regs.sv
logic/bar_colour.sv
logic/pixel_out.sv
logic/raster_bars_top.sv
dv/raster_checker.sv
dv/tb_raster_bars.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the raster bar testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f project.f \
    --top-module tb_raster_bars -o sim_raster
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_raster > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
    exit 1
fi
exit 0
